// ==== source/rab_pkg.sv ====
// rab_pkg
// Shared widths, counts, response codes and channel structs for the read
// half of the remapping address block.

package rab_pkg;

  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_ID_WIDTH   = 4;
  localparam int AXI_USER_WIDTH = 4;

  localparam int NUM_SLICES      = 4;
  localparam int DROP_FIFO_DEPTH = 8;
  localparam int DROP_PTR_WIDTH  = $clog2(DROP_FIFO_DEPTH);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // word address on the configuration port, four words per slice
  localparam int WB_ADDR_WIDTH = 6;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                len;
    logic [2:0]                prot;
    // bit 0 marks a prefetch request
    logic [AXI_USER_WIDTH-1:0] user;
  } ar_req_t;

  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr_start;
    logic [AXI_ADDR_WIDTH-1:0] addr_end;
    logic [AXI_ADDR_WIDTH-1:0] offset;
    logic                      en;
    logic                      rd_en;
  } slice_cfg_t;

  typedef struct packed {
    logic                      match;
    logic                      allow;
    logic [AXI_ADDR_WIDTH-1:0] addr;
  } slice_res_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [1:0]                resp;
    logic                      last;
    logic [AXI_USER_WIDTH-1:0] user;
  } r_chan_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0] id;
    logic [7:0]              len;
    logic                    prefetch;
    logic                    hit;
  } drop_meta_t;

endpackage

// ==== source/rab_cfg_wb.sv ====
// rab_cfg_wb
// Wishbone classic register file that holds the address slice rules.
// Each slice takes four words: start, end, offset and flags.

`timescale 1ns/1ps

module rab_cfg_wb (
  input  logic                                          axi4_aclk,
  input  logic                                          axi4_arstn,
  input  logic                                          wb_cyc_i,
  input  logic                                          wb_stb_i,
  input  logic                                          wb_we_i,
  input  logic [rab_pkg::WB_ADDR_WIDTH-1:0]             wb_adr_i,
  input  logic [rab_pkg::AXI_ADDR_WIDTH-1:0]            wb_dat_i,
  output logic [rab_pkg::AXI_ADDR_WIDTH-1:0]            wb_dat_o,
  output logic                                          wb_ack_o,
  output rab_pkg::slice_cfg_t [rab_pkg::NUM_SLICES-1:0] cfg_o
);

  rab_pkg::slice_cfg_t [rab_pkg::NUM_SLICES-1:0] cfg_q;
  logic                                          ack_q;
  logic                                          access;
  logic                                          in_range;
  logic [1:0]                                    sel_slice;
  logic [1:0]                                    sel_field;
  logic [rab_pkg::AXI_ADDR_WIDTH-1:0]            rd_word;

  // word address splits into slice number and field within the slice
  assign sel_field = wb_adr_i[1:0];
  assign sel_slice = wb_adr_i[3:2];
  assign in_range  = (wb_adr_i[rab_pkg::WB_ADDR_WIDTH-1:4] == '0);

  // a new access is taken only when no ack is pending, so acks never run back to back
  assign access = wb_cyc_i & wb_stb_i & ~ack_q;

  always_comb begin
    rd_word = '0;
    if (in_range) begin
      case (sel_field)
        2'd0: rd_word = cfg_q[sel_slice].addr_start;
        2'd1: rd_word = cfg_q[sel_slice].addr_end;
        2'd2: rd_word = cfg_q[sel_slice].offset;
        default: rd_word = {30'b0, cfg_q[sel_slice].rd_en, cfg_q[sel_slice].en};
      endcase
    end
  end

  always_ff @(posedge axi4_aclk, negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      ack_q <= 1'b0;
      cfg_q <= '0;
    end else begin
      ack_q <= access;
      if (access && wb_we_i && in_range) begin
        case (sel_field)
          2'd0: cfg_q[sel_slice].addr_start <= wb_dat_i;
          2'd1: cfg_q[sel_slice].addr_end   <= wb_dat_i;
          2'd2: cfg_q[sel_slice].offset     <= wb_dat_i;
          default: begin
            cfg_q[sel_slice].en    <= wb_dat_i[0];
            cfg_q[sel_slice].rd_en <= wb_dat_i[1];
          end
        endcase
      end
    end
  end

  // read data is captured with the access and held for the ack cycle
  always_ff @(posedge axi4_aclk) begin
    if (access) begin
      wb_dat_o <= rd_word;
    end
  end

  assign wb_ack_o = ack_q;
  assign cfg_o    = cfg_q;

  a_ack_single: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    wb_ack_o |=> !wb_ack_o);

endmodule

// ==== source/rab_ar_buffer.sv ====
// rab_ar_buffer
// One-entry register stage for upstream AR requests, refillable in the
// cycle it is popped.

`timescale 1ns/1ps

module rab_ar_buffer (
  input  logic             axi4_aclk,
  input  logic             axi4_arstn,
  input  rab_pkg::ar_req_t s_ar_i,
  input  logic             s_arvalid_i,
  output logic             s_arready_o,
  output rab_pkg::ar_req_t req_o,
  output logic             req_valid_o,
  input  logic             req_pop_i
);

  rab_pkg::ar_req_t req_q;
  logic             valid_q;
  logic             active_q;
  logic             load;

  // ready stays low until the first cycle after reset has passed
  assign s_arready_o = active_q & (~valid_q | req_pop_i);
  assign load        = s_arvalid_i & s_arready_o;

  always_ff @(posedge axi4_aclk, negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      active_q <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (load) begin
        valid_q <= 1'b1;
      end else if (req_pop_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (load) begin
      req_q <= s_ar_i;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = valid_q;

  a_req_hold: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (req_valid_o && !req_pop_i) |=> (req_valid_o && $stable(req_o)));

endmodule

// ==== source/rab_slice.sv ====
// rab_slice
// Checks one read request against one slice rule and computes the
// translated address.

`timescale 1ns/1ps

module rab_slice (
  input  rab_pkg::ar_req_t    req_i,
  input  rab_pkg::slice_cfg_t cfg_i,
  output rab_pkg::slice_res_t res_o
);

  logic above_start;
  logic below_end;

  // both bounds are inclusive
  assign above_start = (req_i.addr >= cfg_i.addr_start);
  assign below_end   = (req_i.addr <= cfg_i.addr_end);

  assign res_o.match = cfg_i.en & above_start & below_end;
  assign res_o.allow = cfg_i.rd_en;
  assign res_o.addr  = req_i.addr - cfg_i.addr_start + cfg_i.offset;

endmodule

// ==== source/rab_ar_decide.sv ====
// rab_ar_decide
// Selects the lowest matching slice, then forwards the request downstream
// with its translated address or posts it to the drop path.

`timescale 1ns/1ps

module rab_ar_decide (
  input  logic                                          axi4_aclk,
  input  logic                                          axi4_arstn,
  input  rab_pkg::ar_req_t                              req_i,
  input  logic                                          req_valid_i,
  output logic                                          req_pop_o,
  input  rab_pkg::slice_res_t [rab_pkg::NUM_SLICES-1:0] res_i,
  output rab_pkg::ar_req_t                              m_ar_o,
  output logic                                          m_arvalid_o,
  input  logic                                          m_arready_i,
  output logic                                          drop_o,
  output rab_pkg::drop_meta_t                           drop_meta_o,
  input  logic                                          drop_done_i
);

  logic                               hit;
  logic                               allow;
  logic [rab_pkg::AXI_ADDR_WIDTH-1:0] win_addr;

  // scan from the top so the lowest matching index is the one that remains
  always_comb begin
    hit      = 1'b0;
    allow    = 1'b0;
    win_addr = req_i.addr;
    for (int i = rab_pkg::NUM_SLICES - 1; i >= 0; i--) begin
      if (res_i[i].match) begin
        hit      = 1'b1;
        allow    = res_i[i].allow;
        win_addr = res_i[i].addr;
      end
    end
  end

  always_comb begin
    m_ar_o      = req_i;
    m_ar_o.addr = win_addr;
  end

  assign m_arvalid_o = req_valid_i & hit & allow;
  assign drop_o      = req_valid_i & ~(hit & allow);

  // hit tells the response generator whether a slice matched but refused the read
  assign drop_meta_o.id       = req_i.id;
  assign drop_meta_o.len      = req_i.len;
  assign drop_meta_o.prefetch = req_i.user[0];
  assign drop_meta_o.hit      = hit;

  // the entry leaves on the downstream handshake or once the drop FIFO took it
  assign req_pop_o = (m_arvalid_o & m_arready_i) | drop_done_i;

  a_fwd_xor_drop: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    !(drop_o && m_arvalid_o));

endmodule

// ==== source/axi4_r_sender.sv ====
// axi4_r_sender
// Merges downstream R beats with generated responses for dropped reads.
// Dropped responses are queued and sent only between downstream bursts.

`timescale 1ns/1ps

module axi4_r_sender (
  input  logic                axi4_aclk,
  input  logic                axi4_arstn,
  input  logic                drop_i,
  input  rab_pkg::drop_meta_t drop_meta_i,
  output logic                done_o,
  output rab_pkg::r_chan_t    s_r_o,
  output logic                s_rvalid_o,
  input  logic                s_rready_i,
  input  rab_pkg::r_chan_t    m_r_i,
  input  logic                m_rvalid_i,
  output logic                m_rready_o
);

  typedef enum logic {
    FORWARDING,
    DROPPING
  } state_e;

  rab_pkg::drop_meta_t fifo_mem [rab_pkg::DROP_FIFO_DEPTH];
  logic [rab_pkg::DROP_PTR_WIDTH-1:0] wr_ptr_q;
  logic [rab_pkg::DROP_PTR_WIDTH-1:0] rd_ptr_q;
  logic [rab_pkg::DROP_PTR_WIDTH:0]   count_q;
  logic                               fifo_push;
  logic                               fifo_pop;
  logic                               fifo_ready;
  logic                               fifo_valid;
  rab_pkg::drop_meta_t                meta;

  state_e     state_d;
  state_e     state_q;
  logic       burst_ongoing_d;
  logic       burst_ongoing_q;
  logic [7:0] drop_cnt_d;
  logic [7:0] drop_cnt_q;
  logic       dropping;
  logic [1:0] drop_resp;

  // drop FIFO
  assign fifo_ready = (count_q != rab_pkg::DROP_FIFO_DEPTH[rab_pkg::DROP_PTR_WIDTH:0]);
  assign fifo_valid = (count_q != '0);
  assign fifo_push  = drop_i & fifo_ready;
  assign done_o     = fifo_push;
  assign meta       = fifo_mem[rd_ptr_q];

  always_ff @(posedge axi4_aclk, negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (fifo_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (fifo_push && !fifo_pop) begin
        count_q <= count_q + 1'b1;
      end else if (fifo_pop && !fifo_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge axi4_aclk) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= drop_meta_i;
    end
  end

  always_comb begin
    state_d         = state_q;
    burst_ongoing_d = burst_ongoing_q;
    drop_cnt_d      = drop_cnt_q;
    dropping        = 1'b0;
    fifo_pop        = 1'b0;

    case (state_q)
      FORWARDING: begin
        // track whether a downstream burst has started but not yet ended
        if (m_rvalid_i && m_rready_o) begin
          burst_ongoing_d = ~m_r_i.last;
        end
        // a downstream beat already offered upstream keeps the channel until it is taken
        if (!burst_ongoing_d && fifo_valid && !(m_rvalid_i && !s_rready_i)) begin
          drop_cnt_d = meta.len;
          state_d    = DROPPING;
        end
      end
      DROPPING: begin
        dropping = 1'b1;
        if (s_rready_i) begin
          if (drop_cnt_q == '0) begin
            fifo_pop = 1'b1;
            state_d  = FORWARDING;
          end else begin
            drop_cnt_d = drop_cnt_q - 8'd1;
          end
        end
      end
      default: begin
        state_d = FORWARDING;
      end
    endcase
  end

  always_ff @(posedge axi4_aclk, negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state_q         <= FORWARDING;
      burst_ongoing_q <= 1'b0;
      drop_cnt_q      <= '0;
    end else begin
      state_q         <= state_d;
      burst_ongoing_q <= burst_ongoing_d;
      drop_cnt_q      <= drop_cnt_d;
    end
  end

  // only a prefetch that hit a slice without read permission is answered with OKAY
  assign drop_resp = (meta.prefetch && meta.hit) ? rab_pkg::RESP_OKAY : rab_pkg::RESP_SLVERR;

  assign s_r_o.id   = dropping ? meta.id : m_r_i.id;
  assign s_r_o.data = m_r_i.data;
  assign s_r_o.resp = dropping ? drop_resp : m_r_i.resp;
  assign s_r_o.last = dropping ? (drop_cnt_q == '0) : m_r_i.last;
  assign s_r_o.user = dropping ? '0 : m_r_i.user;

  assign s_rvalid_o = dropping | m_rvalid_i;
  assign m_rready_o = ~dropping & s_rready_i;

  // the beat counter of a drop never runs past the length it was loaded with
  a_cnt_no_underflow: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (state_q == DROPPING) |-> (fifo_valid && drop_cnt_q <= meta.len));

endmodule

// ==== source/rab_read_top.sv ====
// rab_read_top
// Read half of the remapping address block with its Wishbone rule port.

`timescale 1ns/1ps

module rab_read_top (
  input  logic                               axi4_aclk,
  input  logic                               axi4_arstn,
  input  rab_pkg::ar_req_t                   s_ar_i,
  input  logic                               s_arvalid_i,
  output logic                               s_arready_o,
  output rab_pkg::r_chan_t                   s_r_o,
  output logic                               s_rvalid_o,
  input  logic                               s_rready_i,
  output rab_pkg::ar_req_t                   m_ar_o,
  output logic                               m_arvalid_o,
  input  logic                               m_arready_i,
  input  rab_pkg::r_chan_t                   m_r_i,
  input  logic                               m_rvalid_i,
  output logic                               m_rready_o,
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [rab_pkg::WB_ADDR_WIDTH-1:0]  wb_adr_i,
  input  logic [rab_pkg::AXI_ADDR_WIDTH-1:0] wb_dat_i,
  output logic [rab_pkg::AXI_ADDR_WIDTH-1:0] wb_dat_o,
  output logic                               wb_ack_o
);

  rab_pkg::slice_cfg_t [rab_pkg::NUM_SLICES-1:0] cfg;
  rab_pkg::slice_res_t [rab_pkg::NUM_SLICES-1:0] res;
  rab_pkg::ar_req_t                              req;
  logic                                          req_valid;
  logic                                          req_pop;
  logic                                          drop;
  rab_pkg::drop_meta_t                           drop_meta;
  logic                                          drop_done;

  rab_cfg_wb i_cfg_wb (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .cfg_o      (cfg)
  );

  rab_ar_buffer i_ar_buffer (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .s_ar_i      (s_ar_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .req_o       (req),
    .req_valid_o (req_valid),
    .req_pop_i   (req_pop)
  );

  for (genvar g = 0; g < rab_pkg::NUM_SLICES; g++) begin : gen_slice
    rab_slice i_slice (
      .req_i (req),
      .cfg_i (cfg[g]),
      .res_o (res[g])
    );
  end

  rab_ar_decide i_ar_decide (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_pop_o   (req_pop),
    .res_i       (res),
    .m_ar_o      (m_ar_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .drop_o      (drop),
    .drop_meta_o (drop_meta),
    .drop_done_i (drop_done)
  );

  axi4_r_sender i_r_sender (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .drop_i      (drop),
    .drop_meta_i (drop_meta),
    .done_o      (drop_done),
    .s_r_o       (s_r_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .m_r_i       (m_r_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o)
  );

endmodule

// ==== test/tb_rab_read.sv ====
// tb_rab_read
// Testbench for the RAB read path. It programs the slices over Wishbone,
// issues reads, models downstream memory and checks every response.

`timescale 1ns/1ps

module tb_rab_read;

  localparam int CLK_HALF_NS     = 20;
  localparam int NUM_REQS        = 15;
  localparam int WB_OPS          = 32;
  localparam int WATCHDOG_CYCLES = (NUM_REQS * 200) + (WB_OPS * 4);
  localparam int NUM_IDS         = 2 ** rab_pkg::AXI_ID_WIDTH;

  typedef logic [rab_pkg::WB_ADDR_WIDTH-1:0] wb_adr_t;

  logic             axi4_aclk;
  logic             axi4_arstn;
  rab_pkg::ar_req_t s_ar;
  logic             s_arvalid;
  logic             s_arready;
  rab_pkg::r_chan_t s_r;
  logic             s_rvalid;
  logic             s_rready;
  rab_pkg::ar_req_t m_ar;
  logic             m_arvalid;
  logic             m_arready;
  rab_pkg::r_chan_t m_r;
  logic             m_rvalid;
  logic             m_rready;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  wb_adr_t          wb_adr;
  logic [31:0]      wb_wdat;
  logic [31:0]      wb_rdat;
  logic             wb_ack;

  // slice rules as the testbench wrote them
  logic [31:0] rule_start [rab_pkg::NUM_SLICES];
  logic [31:0] rule_end   [rab_pkg::NUM_SLICES];
  logic [31:0] rule_off   [rab_pkg::NUM_SLICES];
  logic [1:0]  rule_flags [rab_pkg::NUM_SLICES];

  // expected outcome of each open read, indexed by id
  logic        exp_live [NUM_IDS];
  logic        exp_fwd  [NUM_IDS];
  logic [31:0] exp_addr [NUM_IDS];
  logic [7:0]  exp_len  [NUM_IDS];
  logic [1:0]  exp_resp [NUM_IDS];
  int          exp_beat [NUM_IDS];

  int               value_errs;
  int               other_errs;
  int               outstanding;
  logic             fwd_open;
  logic [3:0]       fwd_open_id;
  logic [31:0]      rng_state;
  rab_pkg::ar_req_t mem_q [$];
  int               mem_beat;
  logic             beat_held;
  rab_pkg::r_chan_t held_r;

  rab_read_top i_dut (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .s_ar_i      (s_ar),
    .s_arvalid_i (s_arvalid),
    .s_arready_o (s_arready),
    .s_r_o       (s_r),
    .s_rvalid_o  (s_rvalid),
    .s_rready_i  (s_rready),
    .m_ar_o      (m_ar),
    .m_arvalid_o (m_arvalid),
    .m_arready_i (m_arready),
    .m_r_i       (m_r),
    .m_rvalid_i  (m_rvalid),
    .m_rready_o  (m_rready),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_wdat),
    .wb_dat_o    (wb_rdat),
    .wb_ack_o    (wb_ack)
  );

  initial axi4_aclk = 1'b0;
  always #(CLK_HALF_NS) axi4_aclk = ~axi4_aclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] region_base(input logic [1:0] sel);
    case (sel)
      2'd0: return 32'h1000_0000;
      2'd1: return 32'h2000_0000;
      2'd2: return 32'h3000_0000;
      default: return 32'h1001_0000;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    value_errs++;
    $display("ERR %0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
  endtask

  task automatic report_failure(input string what);
    other_errs++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic wb_access(input logic we, input wb_adr_t adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    @(posedge axi4_aclk);
    #1;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = wdat;
    @(posedge axi4_aclk);
    #1;
    assert (wb_ack) else report_failure("wb_ack_o did not rise one cycle after stb");
    rdat   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge axi4_aclk);
    #1;
    assert (!wb_ack) else report_failure("wb_ack_o lasted longer than one cycle");
  endtask

  task automatic wb_write(input wb_adr_t adr, input logic [31:0] dat);
    logic [31:0] ignored;
    wb_access(1'b1, adr, dat, ignored);
    // word address map: slice in bits 3:2, field in bits 1:0
    case (adr[1:0])
      2'd0: rule_start[adr[3:2]] = dat;
      2'd1: rule_end[adr[3:2]]   = dat;
      2'd2: rule_off[adr[3:2]]   = dat;
      default: rule_flags[adr[3:2]] = dat[1:0];
    endcase
  endtask

  task automatic wb_check(input wb_adr_t adr, input logic [31:0] expected);
    logic [31:0] rdat;
    wb_access(1'b0, adr, 32'h0, rdat);
    assert (rdat == expected) else report_mismatch("wb_dat_o", expected, rdat);
  endtask

  task automatic program_slice(input int k, input logic [31:0] lo, input logic [31:0] hi,
                               input logic [31:0] off, input logic [1:0] flags);
    wb_write(wb_adr_t'(4 * k), lo);
    wb_write(wb_adr_t'(4 * k + 1), hi);
    wb_write(wb_adr_t'(4 * k + 2), off);
    wb_write(wb_adr_t'(4 * k + 3), {30'b0, flags});
  endtask

  // expected result of a read from the rules written so far
  task automatic predict(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                         input logic prefetch);
    int win;
    win = -1;
    for (int k = 0; k < rab_pkg::NUM_SLICES; k++) begin
      if (win < 0 && rule_flags[k][0] && addr >= rule_start[k] && addr <= rule_end[k]) begin
        win = k;
      end
    end
    exp_live[id] = 1'b1;
    exp_len[id]  = len;
    exp_beat[id] = 0;
    exp_fwd[id]  = 1'b0;
    exp_addr[id] = 32'h0;
    exp_resp[id] = rab_pkg::RESP_SLVERR;
    if (win >= 0 && rule_flags[win][1]) begin
      exp_fwd[id]  = 1'b1;
      exp_addr[id] = addr - rule_start[win] + rule_off[win];
      exp_resp[id] = rab_pkg::RESP_OKAY;
    end else if (win >= 0 && prefetch) begin
      exp_resp[id] = rab_pkg::RESP_OKAY;
    end
  endtask

  task automatic issue_read(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                            input logic prefetch);
    predict(id, addr, len, prefetch);
    outstanding++;
    @(posedge axi4_aclk);
    #1;
    s_ar.id   = id;
    s_ar.addr = addr;
    s_ar.len  = len;
    s_ar.prot = 3'b0;
    s_ar.user = {3'b0, prefetch};
    s_arvalid = 1'b1;
    do @(posedge axi4_aclk); while (!s_arready);
    #1;
    s_arvalid = 1'b0;
  endtask

  task automatic check_downstream_ar();
    logic [3:0] id;
    id = m_ar.id;
    assert (exp_live[id] && exp_fwd[id])
      else report_failure("downstream AR for a read that should have been dropped");
    if (exp_live[id]) begin
      assert (m_ar.addr == exp_addr[id])
        else report_mismatch("m_ar_o.addr", exp_addr[id], m_ar.addr);
      assert (m_ar.len == exp_len[id])
        else report_mismatch("m_ar_o.len", 32'(exp_len[id]), 32'(m_ar.len));
    end
  endtask

  // a beat that was not taken must be offered again unchanged
  task automatic check_held_beat();
    assert (s_rvalid) else report_failure("s_rvalid_o fell before the beat was accepted");
    assert (s_r.id == held_r.id)
      else report_mismatch("s_r_o.id", 32'(held_r.id), 32'(s_r.id));
    assert (s_r.resp == held_r.resp)
      else report_mismatch("s_r_o.resp", 32'(held_r.resp), 32'(s_r.resp));
    assert (s_r.last == held_r.last)
      else report_mismatch("s_r_o.last", 32'(held_r.last), 32'(s_r.last));
    if (exp_fwd[held_r.id]) begin
      assert (s_r.data == held_r.data) else report_mismatch("s_r_o.data", held_r.data, s_r.data);
    end
  endtask

  task automatic check_upstream_beat();
    logic [3:0]  id;
    logic        final_beat;
    logic [31:0] data_exp;
    id = s_r.id;
    assert (exp_live[id]) else report_failure("upstream R beat with an id that has no open read");
    if (exp_live[id]) begin
      final_beat = (exp_beat[id] == int'(exp_len[id]));
      data_exp   = exp_addr[id] + 32'(exp_beat[id]);
      assert (s_r.last == final_beat)
        else report_mismatch("s_r_o.last", 32'(final_beat), 32'(s_r.last));
      assert (s_r.resp == exp_resp[id])
        else report_mismatch("s_r_o.resp", 32'(exp_resp[id]), 32'(s_r.resp));
      if (exp_fwd[id]) begin
        assert (s_r.data == data_exp) else report_mismatch("s_r_o.data", data_exp, s_r.data);
        assert (!fwd_open || fwd_open_id == id)
          else report_failure("beat of another read inside a forwarded burst");
        fwd_open    = !final_beat;
        fwd_open_id = id;
      end else begin
        assert (!fwd_open) else report_failure("dropped beat inside a forwarded burst");
        assert (s_r.user == '0) else report_mismatch("s_r_o.user", 32'h0, 32'(s_r.user));
      end
      exp_beat[id]++;
      if (final_beat) begin
        exp_live[id] = 1'b0;
        outstanding--;
      end
    end
  endtask

  // downstream memory model and upstream monitor, sampled on the edge
  always @(posedge axi4_aclk) begin : memory_and_monitor
    logic        r_hs;
    logic [31:0] rnd;
    r_hs = m_rvalid && m_rready;
    if (axi4_arstn) begin
      if (m_arvalid && m_arready) begin
        check_downstream_ar();
        mem_q.push_back(m_ar);
      end
      if (beat_held) begin
        check_held_beat();
      end
      beat_held = s_rvalid && !s_rready;
      held_r    = s_r;
      if (s_rvalid && s_rready) begin
        check_upstream_beat();
      end
      if (r_hs && mem_q.size() > 0) begin
        if (mem_beat == int'(mem_q[0].len)) begin
          mem_q.delete(0);
          mem_beat = 0;
        end else begin
          mem_beat++;
        end
      end
    end
    #1;
    rnd      = next_random();
    s_rready = axi4_arstn && (rnd[1:0] != 2'b00);
    // a raised rvalid holds its beat until it is taken
    if (!m_rvalid || r_hs) begin
      m_rvalid = 1'b0;
      if (axi4_arstn && mem_q.size() > 0 && rnd[4]) begin
        m_r.id   = mem_q[0].id;
        m_r.data = mem_q[0].addr + 32'(mem_beat);
        m_r.resp = rab_pkg::RESP_OKAY;
        m_r.last = (mem_beat == int'(mem_q[0].len));
        m_r.user = '1;
        m_rvalid = 1'b1;
      end
    end
  end

  a_ack_follows_stb: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else report_failure("wb_ack_o rose without cyc and stb in the cycle before");

  a_ack_one_cycle: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    wb_ack |=> !wb_ack)
    else report_failure("wb_ack_o stayed high for two cycles");

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge axi4_aclk);
    $display("watchdog expired: %0d reads outstanding, %0d value errors, %0d other errors",
             outstanding, value_errs, other_errs);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rnd;
    rng_state  = 32'h82d8b65a;
    rnd        = 32'h82d8b65a;
    value_errs = 0;
    other_errs = 0;
    outstanding = 0;
    fwd_open    = 1'b0;
    fwd_open_id = 4'h0;
    mem_beat    = 0;
    beat_held   = 1'b0;
    axi4_arstn = 1'b0;
    s_ar       = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    m_arready  = 1'b0;
    m_r        = '0;
    m_rvalid   = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_wdat    = 32'h0;
    for (int k = 0; k < rab_pkg::NUM_SLICES; k++) begin
      rule_start[k] = 32'h0;
      rule_end[k]   = 32'h0;
      rule_off[k]   = 32'h0;
      rule_flags[k] = 2'b0;
    end
    for (int i = 0; i < NUM_IDS; i++) begin
      exp_live[i] = 1'b0;
    end
    repeat (3) @(posedge axi4_aclk);
    assert (!s_arready && !m_arvalid && !s_rvalid && !wb_ack)
      else report_failure("an output was high during reset");
    #1;
    axi4_arstn = 1'b1;
    m_arready  = 1'b1;

    // slice 2 overlaps the upper half of slice 0, slice 3 stays disabled
    program_slice(0, 32'h1000_0000, 32'h1000_ffff, 32'h8000_0000, 2'b11);
    program_slice(1, 32'h2000_0000, 32'h2000_0fff, 32'h0000_0000, 2'b01);
    program_slice(2, 32'h1000_8000, 32'h1001_ffff, 32'h4000_0000, 2'b11);
    program_slice(3, 32'h3000_0000, 32'h3000_ffff, 32'h5000_0000, 2'b10);
    for (int k = 0; k < rab_pkg::NUM_SLICES; k++) begin
      wb_check(wb_adr_t'(4 * k), rule_start[k]);
      wb_check(wb_adr_t'(4 * k + 1), rule_end[k]);
      wb_check(wb_adr_t'(4 * k + 2), rule_off[k]);
      wb_check(wb_adr_t'(4 * k + 3), {30'b0, rule_flags[k]});
    end

    issue_read(4'd1, 32'h1000_0100, 8'd3, 1'b0);
    issue_read(4'd2, 32'h1000_0200, 8'd0, 1'b0);
    issue_read(4'd3, 32'h4000_0000, 8'd2, 1'b0);
    issue_read(4'd4, 32'h3000_0010, 8'd1, 1'b1);
    issue_read(4'd5, 32'h2000_0040, 8'd3, 1'b1);
    issue_read(4'd6, 32'h2000_0080, 8'd1, 1'b0);
    issue_read(4'd7, 32'h1000_9000, 8'd1, 1'b0);
    // a long forwarded burst that is already open when the next drop arrives
    issue_read(4'd8, 32'h1000_1000, 8'd15, 1'b0);
    wait (fwd_open && fwd_open_id == 4'd8);
    issue_read(4'd9, 32'h5000_0000, 8'd2, 1'b0);
    issue_read(4'd10, 32'h1001_8000, 8'd4, 1'b0);
    issue_read(4'd11, 32'h2000_0000, 8'd0, 1'b1);
    for (int n = 12; n < 16; n++) begin
      rnd = xorshift32(rnd);
      issue_read(4'(n), region_base(rnd[1:0]) + {16'b0, rnd[15:2], 2'b00},
                 {5'b0, rnd[18:16]}, rnd[20]);
    end

    wait (outstanding == 0);
    repeat (4) @(posedge axi4_aclk);
    assert (mem_q.size() == 0) else report_failure("downstream reads left unanswered");
    $display("tb_rab_read done: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
source/rab_pkg.sv
source/rab_cfg_wb.sv
source/rab_ar_buffer.sv
source/rab_slice.sv
source/rab_ar_decide.sv
source/axi4_r_sender.sv
source/rab_read_top.sv
test/tb_rab_read.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the RAB read testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --top-module tb_rab_read \
  -Mdir "$BUILD_DIR" -o tb_rab_read -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_rab_read" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
exit 0
